// ==== rtl/vram_pkg.sv ====
//------------------
// shared sizes and types for the VRAM subsystem
// import with vram_pkg::* in the module header
//------------------
`default_nettype none

package vram_pkg;

    localparam int VRAM_AW         = 16;
    // only the low address bits reach the array
    localparam int VRAM_DEPTH      = 4096;
    localparam int PIX_W           = 4;
    localparam int PIX_PER_WORD    = 4;

    // video fetch cadence
    localparam int VGEN_PERIOD     = 4;
    localparam int VGEN_LINE_WORDS = 8;

    // one VRAM word, raw for the host, per pixel for masked writes
    typedef union packed {
        logic [PIX_W*PIX_PER_WORD-1:0]      raw;
        logic [PIX_PER_WORD-1:0][PIX_W-1:0] pix;
    } vram_word_u;

    // client slot request as seen by the arbiter
    typedef struct packed {
        logic                    sel;
        logic                    wr;
        logic [PIX_PER_WORD-1:0] mask;
        logic [VRAM_AW-1:0]      addr;
        vram_word_u              data;
    } vram_req_s;

    // external request payload, held stable while req is high
    typedef struct packed {
        logic                    wr;
        logic [PIX_PER_WORD-1:0] mask;
        logic [VRAM_AW-1:0]      addr;
        vram_word_u              data;
    } client_req_s;

endpackage

`default_nettype wire

// ==== rtl/vram_ram.sv ====
//------------------
// single-port video RAM, registered read, pixel-masked write
//------------------
`default_nettype none
`timescale 1ns/10ps

module vram_ram
    import vram_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    sel_i,
    input  wire logic                    wr_i,
    input  wire logic [PIX_PER_WORD-1:0] mask_i,
    input  wire logic [VRAM_AW-1:0]      addr_i,
    input  wire vram_word_u              data_i,
    output vram_word_u                   data_o
);

    localparam int IDX_W = $clog2(VRAM_DEPTH);

    vram_word_u       mem [VRAM_DEPTH];
    vram_word_u       merged;
    logic [IDX_W-1:0] idx;

    // address wraps modulo the depth
    assign idx = addr_i[IDX_W-1:0];

    // keep stored pixels where the mask bit is clear
    always_comb begin
        merged = mem[idx];
        for (int i = 0; i < PIX_PER_WORD; i++) begin
            if (mask_i[i]) begin
                merged.pix[i] = data_i.pix[i];
            end
        end
    end

    // a write returns the merged word on the data output
    always_ff @(posedge clk) begin
        if (sel_i) begin
            if (wr_i) begin
                mem[idx] <= merged;
                data_o   <= merged;
            end else begin
                data_o   <= mem[idx];
            end
        end
    end

    // the arbiter must present a fully known address and direction
    a_addr_known: assert property (@(posedge clk) sel_i |-> !$isunknown({wr_i, addr_i}));

endmodule

`default_nettype wire

// ==== rtl/vram_arb.sv ====
//------------------
// fixed priority VRAM arbiter: vgen, regs, blit, draw
// winner drives the RAM directly, ack follows one cycle later
//------------------
`default_nettype none
`timescale 1ns/10ps

module vram_arb
    import vram_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst_n_i,

    // video fetch, read only
    input  wire logic               vgen_sel_i,
    input  wire logic [VRAM_AW-1:0] vgen_addr_i,

    // client slots
    input  wire vram_req_s          regs_req_i,
    input  wire vram_req_s          blit_req_i,
    input  wire vram_req_s          draw_req_i,
    output logic                    regs_ack_o,
    output logic                    blit_ack_o,
    output logic                    draw_ack_o,

    // shared read data, valid with the ack
    output vram_word_u              vram_data_o
);

    vram_req_s  win;
    logic [2:0] pend;
    logic [2:0] ack_d;
    logic [2:0] ack_q;

    // a slot already acked this cycle is not served again
    assign pend[0] = regs_req_i.sel & ~ack_q[0];
    assign pend[1] = blit_req_i.sel & ~ack_q[1];
    assign pend[2] = draw_req_i.sel & ~ack_q[2];

    always_comb begin
        win   = '0;
        ack_d = '0;
        if (vgen_sel_i) begin
            // vgen never writes, mask and data stay zero
            win.sel  = 1'b1;
            win.addr = vgen_addr_i;
        end else if (pend[0]) begin
            win      = regs_req_i;
            ack_d[0] = 1'b1;
        end else if (pend[1]) begin
            win      = blit_req_i;
            ack_d[1] = 1'b1;
        end else if (pend[2]) begin
            win      = draw_req_i;
            ack_d[2] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= '0;
        end else begin
            ack_q <= ack_d;
        end
    end

    assign regs_ack_o = ack_q[0];
    assign blit_ack_o = ack_q[1];
    assign draw_ack_o = ack_q[2];

    vram_ram ram0 (
        .clk    (clk),
        .sel_i  (win.sel),
        .wr_i   (win.wr),
        .mask_i (win.mask),
        .addr_i (win.addr),
        .data_i (win.data),
        .data_o (vram_data_o)
    );

    // one RAM access per cycle means one ack per cycle
    a_ack_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0(ack_q));

    // each grant yields a single ack pulse
    a_regs_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        regs_ack_o |=> !regs_ack_o);
    a_blit_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        blit_ack_o |=> !blit_ack_o);
    a_draw_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        draw_ack_o |=> !draw_ack_o);

endmodule

`default_nettype wire

// ==== rtl/vram_client_port.sv ====
//------------------
// four-phase req/ack bridge from an external client to one arbiter slot
//------------------
`default_nettype none
`timescale 1ns/10ps

module vram_client_port
    import vram_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n_i,

    // external client side
    input  wire logic        req_i,
    input  wire client_req_s creq_i,
    output logic             ack_o,
    output vram_word_u       rdata_o,

    // arbiter slot side
    output vram_req_s        arb_req_o,
    input  wire logic        arb_ack_i,
    input  wire vram_word_u  arb_data_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PEND,
        ST_DONE
    } state_e;

    state_e      state;
    client_req_s req_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (req_i) state <= ST_PEND;
                ST_PEND: if (arb_ack_i) state <= ST_DONE;
                // hold ack until the client lets go
                ST_DONE: if (!req_i) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload and read data
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_i) begin
            req_q <= creq_i;
        end
        if (state == ST_PEND && arb_ack_i) begin
            rdata_o <= arb_data_i;
        end
    end

    assign ack_o = (state == ST_DONE);

    always_comb begin
        arb_req_o.sel  = (state == ST_PEND);
        arb_req_o.wr   = req_q.wr;
        arb_req_o.mask = req_q.mask;
        arb_req_o.addr = req_q.addr;
        arb_req_o.data = req_q.data;
    end

    a_sel_vs_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
        ack_o |-> !arb_req_o.sel);

    // arbiter only acks a slot that is still asking
    a_ack_needs_sel: assert property (@(posedge clk) disable iff (!rst_n_i)
        arb_ack_i |-> arb_req_o.sel);

endmodule

`default_nettype wire

// ==== rtl/vgen_fetch.sv ====
//------------------
// video line fetch, one read every VGEN_PERIOD cycles from base upward
//------------------
`default_nettype none
`timescale 1ns/10ps

module vgen_fetch
    import vram_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst_n_i,
    input  wire logic               vgen_en_i,
    input  wire logic [VRAM_AW-1:0] vgen_base_i,
    output logic                    vgen_sel_o,
    output logic [VRAM_AW-1:0]      vgen_addr_o,
    input  wire vram_word_u         vram_data_i,
    output vram_word_u              vgen_word_o,
    output logic                    vgen_valid_o
);

    localparam int CNT_W = $clog2(VGEN_PERIOD);
    localparam int IDX_W = $clog2(VGEN_LINE_WORDS);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(VGEN_PERIOD - 1);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(VGEN_LINE_WORDS - 1);

    logic [CNT_W-1:0] cnt;
    logic [IDX_W-1:0] idx;
    vram_word_u       word_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cnt          <= '0;
            idx          <= '0;
            vgen_sel_o   <= 1'b0;
            vgen_valid_o <= 1'b0;
        end else begin
            vgen_valid_o <= vgen_sel_o;
            vgen_sel_o   <= vgen_en_i && (cnt == CNT_LAST);
            if (!vgen_en_i) begin
                cnt <= '0;
                idx <= '0;
            end else begin
                cnt <= (cnt == CNT_LAST) ? '0 : cnt + 1'b1;
                // step to the next word once the read is issued
                if (vgen_sel_o) begin
                    idx <= (idx == IDX_LAST) ? '0 : idx + 1'b1;
                end
            end
        end
    end

    assign vgen_addr_o = vgen_base_i + VRAM_AW'(idx);

    // RAM data is valid with the pulse, hold it between fetches
    always_ff @(posedge clk) begin
        if (vgen_valid_o) begin
            word_q <= vram_data_i;
        end
    end

    assign vgen_word_o = vgen_valid_o ? vram_data_i : word_q;

endmodule

`default_nettype wire

// ==== rtl/vram_sys.sv ====
//------------------
// VRAM subsystem top: three client bridges and video fetch on one RAM
//------------------
`default_nettype none
`timescale 1ns/10ps

module vram_sys
    import vram_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst_n_i,

    input  wire logic               regs_req_i,
    input  wire client_req_s        regs_creq_i,
    output logic                    regs_ack_o,
    output vram_word_u              regs_rdata_o,

    input  wire logic               blit_req_i,
    input  wire client_req_s        blit_creq_i,
    output logic                    blit_ack_o,
    output vram_word_u              blit_rdata_o,

    input  wire logic               draw_req_i,
    input  wire client_req_s        draw_creq_i,
    output logic                    draw_ack_o,
    output vram_word_u              draw_rdata_o,

    input  wire logic               vgen_en_i,
    input  wire logic [VRAM_AW-1:0] vgen_base_i,
    output vram_word_u              vgen_word_o,
    output logic                    vgen_valid_o
);

    vram_req_s          regs_arb_req, blit_arb_req, draw_arb_req;
    logic               regs_arb_ack, blit_arb_ack, draw_arb_ack;
    vram_word_u         vram_data;
    logic               vgen_sel;
    logic [VRAM_AW-1:0] vgen_addr;

    vram_client_port regs_port (
        .clk(clk), .rst_n_i(rst_n_i),
        .req_i(regs_req_i), .creq_i(regs_creq_i), .ack_o(regs_ack_o), .rdata_o(regs_rdata_o),
        .arb_req_o(regs_arb_req), .arb_ack_i(regs_arb_ack), .arb_data_i(vram_data)
    );

    vram_client_port blit_port (
        .clk(clk), .rst_n_i(rst_n_i),
        .req_i(blit_req_i), .creq_i(blit_creq_i), .ack_o(blit_ack_o), .rdata_o(blit_rdata_o),
        .arb_req_o(blit_arb_req), .arb_ack_i(blit_arb_ack), .arb_data_i(vram_data)
    );

    vram_client_port draw_port (
        .clk(clk), .rst_n_i(rst_n_i),
        .req_i(draw_req_i), .creq_i(draw_creq_i), .ack_o(draw_ack_o), .rdata_o(draw_rdata_o),
        .arb_req_o(draw_arb_req), .arb_ack_i(draw_arb_ack), .arb_data_i(vram_data)
    );

    vgen_fetch vgen0 (
        .clk(clk), .rst_n_i(rst_n_i),
        .vgen_en_i(vgen_en_i), .vgen_base_i(vgen_base_i),
        .vgen_sel_o(vgen_sel), .vgen_addr_o(vgen_addr),
        .vram_data_i(vram_data), .vgen_word_o(vgen_word_o), .vgen_valid_o(vgen_valid_o)
    );

    vram_arb arb0 (
        .clk(clk), .rst_n_i(rst_n_i),
        .vgen_sel_i(vgen_sel), .vgen_addr_i(vgen_addr),
        .regs_req_i(regs_arb_req), .blit_req_i(blit_arb_req), .draw_req_i(draw_arb_req),
        .regs_ack_o(regs_arb_ack), .blit_ack_o(blit_arb_ack), .draw_ack_o(draw_arb_ack),
        .vram_data_o(vram_data)
    );

endmodule

`default_nettype wire

// ==== test/vram_sys_tb.sv ====
//--------------------
// self-checking testbench for the VRAM subsystem
// simulate it as the top module with the DUT and memory model inside
//--------------------
`timescale 1ns/10ps
`default_nettype none

module vram_sys_tb
    import vram_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int DRV        = 2;
    localparam int RST_CYCLES = 16;
    localparam int MAX_LAT    = 40;
    localparam int N_MASKED   = 6;
    localparam int N_TRAFFIC  = 6;
    localparam int N_FETCH    = 2 * VGEN_LINE_WORDS + 2;
    // transactions summed over all tests
    localparam int N_TXN      = 2 + 3 * N_MASKED + 6 + VGEN_LINE_WORDS
                              + 3 * (4 + N_TRAFFIC) + N_FETCH;
    localparam logic [15:0] VGEN_BASE = 16'h3010;

    logic        clk;
    logic        rst_n_i;
    logic [2:0]  req;
    client_req_s creq [3];
    logic [2:0]  ack;
    vram_word_u  rdata [3];
    logic        vgen_en;
    logic [15:0] vgen_base;
    vram_word_u  vgen_word;
    logic        vgen_valid;

    logic [31:0] lfsr_q = 32'hbc2d_51ed;
    logic [15:0] model [int];
    logic [15:0] exp_word [3];
    logic [15:0] line_exp [VGEN_LINE_WORDS];
    logic        conc_mode;
    logic [2:0]  ack_q;
    logic [2:0]  ack_rise;
    logic [2:0]  done_q;
    int          vidx = 0;
    int          vcount = 0;
    int          errors = 0;
    string       pname [3] = '{"regs", "blit", "draw"};

    vram_sys dut0 (
        .clk(clk), .rst_n_i(rst_n_i),
        .regs_req_i(req[0]), .regs_creq_i(creq[0]), .regs_ack_o(ack[0]), .regs_rdata_o(rdata[0]),
        .blit_req_i(req[1]), .blit_creq_i(creq[1]), .blit_ack_o(ack[1]), .blit_rdata_o(rdata[1]),
        .draw_req_i(req[2]), .draw_creq_i(creq[2]), .draw_ack_o(ack[2]), .draw_rdata_o(rdata[2]),
        .vgen_en_i(vgen_en), .vgen_base_i(vgen_base),
        .vgen_word_o(vgen_word), .vgen_valid_o(vgen_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    assign ack_rise = ack & ~ack_q;

    // track the line index and which ports have already acked
    always @(posedge clk) begin
        ack_q  <= ack;
        done_q <= conc_mode ? (done_q | ack_rise) : 3'b000;
        if (!vgen_en) begin
            vidx <= 0;
        end else if (vgen_valid) begin
            vidx <= (vidx == VGEN_LINE_WORDS - 1) ? 0 : vidx + 1;
        end
        if (vgen_valid) begin
            vcount <= vcount + 1;
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n_i) |-> (ack == 3'b000 && !vgen_valid))
        else begin
            $display("reset: an ack_o or vgen_valid_o is not low after reset");
            errors++;
        end

    for (genvar p = 0; p < 3; p++) begin : g_port_chk
        a_rdata: assert property (@(posedge clk) disable iff (!rst_n_i)
            $rose(ack[p]) |-> rdata[p].raw == exp_word[p])
            else begin
                $display("Mismatch %s_rdata_o: expected %h, got %h",
                         pname[p], exp_word[p], rdata[p].raw);
                errors++;
            end
    end

    // done flags fill from bit 0 so the next rise must be done_q + 1
    a_ack_order: assert property (@(posedge clk) disable iff (!rst_n_i)
        conc_mode && ack_rise != 3'b000 |-> ack_rise == done_q + 3'd1)
        else begin
            $display("ack order: ack_o rose out of the regs, blit, draw order");
            errors++;
        end

    a_vgen_word: assert property (@(posedge clk) disable iff (!rst_n_i)
        vgen_valid |-> vgen_word.raw == line_exp[vidx])
        else begin
            $display("Mismatch vgen_word_o: expected %h, got %h",
                     line_exp[$sampled(vidx)], vgen_word.raw);
            errors++;
        end

    // fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r      = {r[14:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic int word_index(input logic [15:0] addr);
        return int'(addr) % VRAM_DEPTH;
    endfunction

    function automatic logic [15:0] pixel_merge(input logic [15:0] old_w,
                                                input logic [15:0] new_w,
                                                input logic [3:0]  mask);
        logic [15:0] res;
        res = old_w;
        for (int i = 0; i < PIX_PER_WORD; i++) begin
            if (mask[i]) begin
                res[i*PIX_W +: PIX_W] = new_w[i*PIX_W +: PIX_W];
            end
        end
        return res;
    endfunction

    // bits 11:10 keep the ports apart while random upper bits alias the same word
    function automatic logic [15:0] port_addr(input int p, input int off_bits);
        logic [15:0] up;
        logic [15:0] off;
        up  = rand_bits(4);
        off = rand_bits(off_bits);
        return {up[3:0], 2'(p + 1), off[9:0]};
    endfunction

    task automatic client_access(input int p, input logic wr, input logic [3:0] mask,
                                 input logic [15:0] addr, input logic [15:0] data);
        logic [15:0] cur;
        cur = model.exists(word_index(addr)) ? model[word_index(addr)] : 16'h0;
        if (wr) begin
            cur = pixel_merge(cur, data, mask);
            model[word_index(addr)] = cur;
        end
        exp_word[p]      = cur;
        creq[p].wr       = wr;
        creq[p].mask     = mask;
        creq[p].addr     = addr;
        creq[p].data.raw = data;
        req[p]           = 1'b1;
        do begin
            @(posedge clk);
            #DRV;
        end while (!ack[p]);
        req[p] = 1'b0;
        do begin
            @(posedge clk);
            #DRV;
        end while (ack[p]);
    endtask

    // fill four known slots per port then run random reads and masked writes
    task automatic random_traffic(input int p);
        logic [15:0] r;
        logic [15:0] m;
        logic [15:0] a;
        for (int s = 0; s < 4; s++) begin
            client_access(p, 1'b1, 4'hf, port_addr(p, 0) | 16'(s), rand_bits(16));
        end
        for (int i = 0; i < N_TRAFFIC; i++) begin
            r = rand_bits(1);
            m = rand_bits(4);
            a = port_addr(p, 2);
            client_access(p, r[0], m[3:0], a, rand_bits(16));
        end
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err0);
        end
    endtask

    initial begin
        logic [15:0] a;
        logic [15:0] m;
        logic [15:0] c_addr [3];
        logic [15:0] c_data [3];
        int          err0;
        rst_n_i   = 1'b0;
        req       = 3'b000;
        vgen_en   = 1'b0;
        vgen_base = VGEN_BASE;
        conc_mode = 1'b0;
        for (int p = 0; p < 3; p++) begin
            creq[p] = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        #DRV;
        rst_n_i = 1'b1;
        @(posedge clk);
        #DRV;
        report_test("reset", 0);

        err0 = errors;
        a = port_addr(0, 10);
        client_access(0, 1'b1, 4'hf, a, rand_bits(16));
        client_access(0, 1'b0, 4'h0, a, 16'h0);
        report_test("basic", err0);

        err0 = errors;
        for (int i = 0; i < N_MASKED; i++) begin
            a = port_addr(1, 10);
            client_access(1, 1'b1, 4'hf, a, rand_bits(16));
            m = rand_bits(4);
            client_access(1, 1'b1, m[3:0], a, rand_bits(16));
            client_access(2, 1'b0, 4'h0, a, 16'h0);
        end
        report_test("masked", err0);

        err0 = errors;
        for (int p = 0; p < 3; p++) begin
            c_addr[p] = port_addr(p, 10);
            c_data[p] = rand_bits(16);
        end
        conc_mode = 1'b1;
        fork
            client_access(0, 1'b1, 4'hf, c_addr[0], c_data[0]);
            client_access(1, 1'b1, 4'hf, c_addr[1], c_data[1]);
            client_access(2, 1'b1, 4'hf, c_addr[2], c_data[2]);
        join
        // one edge with the order check off clears the done flags
        conc_mode = 1'b0;
        @(posedge clk);
        #DRV;
        conc_mode = 1'b1;
        fork
            client_access(0, 1'b0, 4'h0, c_addr[0], 16'h0);
            client_access(1, 1'b0, 4'h0, c_addr[1], 16'h0);
            client_access(2, 1'b0, 4'h0, c_addr[2], 16'h0);
        join
        conc_mode = 1'b0;
        report_test("concurrent", err0);

        err0 = errors;
        for (int i = 0; i < VGEN_LINE_WORDS; i++) begin
            client_access(0, 1'b1, 4'hf, VGEN_BASE + 16'(i), rand_bits(16));
            line_exp[i] = model[word_index(VGEN_BASE + 16'(i))];
        end
        vgen_en = 1'b1;
        fork
            random_traffic(0);
            random_traffic(1);
            random_traffic(2);
        join
        do begin
            @(posedge clk);
            #DRV;
        end while (vcount < N_FETCH || !vgen_valid);
        // drop enable right after a fetch pulse and well before the next read
        @(posedge clk);
        #DRV;
        vgen_en = 1'b0;
        report_test("vgen", err0);

        $display("5 tests run, %0d errors", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #((RST_CYCLES + N_TXN * MAX_LAT) * CLK_PERIOD);
        $display("timeout: the tests did not finish within the latency bound");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vram_sys.f ====
rtl/vram_pkg.sv
rtl/vram_ram.sv
rtl/vram_arb.sv
rtl/vram_client_port.sv
rtl/vgen_fetch.sv
rtl/vram_sys.sv
test/vram_sys_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := vram_sys_tb
FILELIST  := vram_sys.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the output
run: $(SIM)
	$(SIM) | awk '{ print } /^STATUS: PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
